//--- rmii_pkg.sv
package rmii_pkg;

    localparam int HEADER_BYTES = 14;

    // Seven preamble bytes then the SFD, newest byte in the top position
    localparam logic [63:0] PREAMBLE_SFD = 64'hd555_5555_5555_5555;

    localparam logic CHECK_DESTINATION = 1'b1; // Drop frames not for the local MAC

    localparam int STAT_WIDTH = 16;

    // Receiver FSM encodings
    localparam logic [1:0] ST_IDLE         = 2'd0;
    localparam logic [1:0] ST_PREAMBLE_SFD = 2'd1;
    localparam logic [1:0] ST_HEADER       = 2'd2;
    localparam logic [1:0] ST_DATA         = 2'd3;

    // Captured Ethernet header, seen as raw bytes or as decoded fields
    typedef union packed {
        logic [0:HEADER_BYTES-1][7:0] bytes; // Byte 0 is the first received
        struct packed {
            logic [47:0] dst_mac;
            logic [47:0] src_mac;
            logic [15:0] ethertype;
        } fields;
    } eth_header_u;

endpackage

//--- rmii_dibit_packer.sv
`timescale 1ns/100ps

module rmii_dibit_packer (
    input  logic       clk_i,
    input  logic       rst_i,
    input  logic       crs_dv_i,
    input  logic [1:0] rxd_i,
    output logic [7:0] byte_o,
    output logic       byte_stb_o,
    output logic       frame_act_o
);

    logic       crs_q;
    logic [1:0] rxd_q;
    logic [1:0] dibit_cnt;

    // Control path
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            crs_q       <= 1'b0;
            dibit_cnt   <= 2'd0;
            byte_stb_o  <= 1'b0;
            frame_act_o <= 1'b0;
        end else begin
            crs_q       <= crs_dv_i;
            frame_act_o <= crs_q; // Trails the final strobe by one cycle
            byte_stb_o  <= crs_q && (dibit_cnt == 2'd3);
            if (crs_q) begin
                dibit_cnt <= dibit_cnt + 2'd1;
            end else begin
                dibit_cnt <= 2'd0; // Partial group is dropped here
            end
        end
    end

    // Data path
    always_ff @(posedge clk_i) begin
        rxd_q <= rxd_i;
        if (crs_q) begin
            byte_o <= {rxd_q, byte_o[7:2]}; // LS dibit first
        end
    end

endmodule

//--- packet_recv.sv
`timescale 1ns/100ps

module packet_recv
    import rmii_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic [7:0]  byte_i,
    input  logic        byte_stb_i,
    input  logic        frame_act_i,
    input  logic [47:0] local_mac_i,
    output logic [7:0]  m_data_o,
    output logic        m_valid_o,
    output logic        m_last_o,
    output logic        frame_ok_o,
    output logic        frame_drop_o,
    output logic        frame_runt_o
);

    logic [1:0]  state;
    logic [3:0]  hdr_cnt;
    logic [63:0] window;
    logic [63:0] window_next;
    eth_header_u hdr;
    eth_header_u hdr_next;
    logic        pass;
    logic        held_vld;
    logic [7:0]  held_byte;

    assign window_next = {byte_i, window[63:8]};

    always_comb begin
        hdr_next.bytes = {hdr.bytes[1:HEADER_BYTES-1], byte_i};
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state        <= ST_IDLE;
            hdr_cnt      <= 4'd0;
            window       <= 64'd0;
            pass         <= 1'b0;
            held_vld     <= 1'b0;
            m_valid_o    <= 1'b0;
            m_last_o     <= 1'b0;
            frame_ok_o   <= 1'b0;
            frame_drop_o <= 1'b0;
            frame_runt_o <= 1'b0;
        end else begin
            m_valid_o    <= 1'b0;
            m_last_o     <= 1'b0;
            frame_ok_o   <= 1'b0;
            frame_drop_o <= 1'b0;
            frame_runt_o <= 1'b0;
            case (state)
                ST_IDLE: begin
                    window   <= 64'd0;
                    hdr_cnt  <= 4'd0;
                    held_vld <= 1'b0;
                    if (frame_act_i) begin
                        state <= ST_PREAMBLE_SFD;
                    end
                end
                ST_PREAMBLE_SFD: begin
                    if (!frame_act_i) begin
                        state <= ST_IDLE; // No SFD seen, nothing to report
                    end else if (byte_stb_i) begin
                        window <= window_next;
                        if (window_next == PREAMBLE_SFD) begin
                            state <= ST_HEADER;
                        end
                    end
                end
                ST_HEADER: begin
                    if (!frame_act_i) begin
                        frame_runt_o <= 1'b1;
                        state        <= ST_IDLE;
                    end else if (byte_stb_i) begin
                        hdr_cnt <= hdr_cnt + 4'd1;
                        if (hdr_cnt == 4'(HEADER_BYTES - 1)) begin
                            // Destination decided once per frame
                            pass  <= !CHECK_DESTINATION ||
                                     (hdr_next.fields.dst_mac == local_mac_i);
                            state <= ST_DATA;
                        end
                    end
                end
                ST_DATA: begin
                    if (!frame_act_i) begin
                        state <= ST_IDLE;
                        if (!held_vld) begin
                            frame_runt_o <= 1'b1; // Header only, no payload
                        end else if (pass) begin
                            m_valid_o  <= 1'b1;
                            m_last_o   <= 1'b1;
                            frame_ok_o <= 1'b1;
                        end else begin
                            frame_drop_o <= 1'b1;
                        end
                    end else if (byte_stb_i) begin
                        held_vld <= 1'b1;
                        if (pass && held_vld) begin
                            m_valid_o <= 1'b1; // Release previous byte
                        end
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Header capture and one-byte hold stage
    always_ff @(posedge clk_i) begin
        if (state == ST_HEADER && byte_stb_i) begin
            hdr <= hdr_next;
        end
        if (state == ST_DATA) begin
            m_data_o <= held_byte; // Qualified by m_valid_o
            if (byte_stb_i) begin
                held_byte <= byte_i;
            end
        end
    end

endmodule

//--- rx_frame_stats.sv
`timescale 1ns/100ps

module rx_frame_stats
    import rmii_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  frame_ok_i,
    input  logic                  frame_drop_i,
    input  logic                  frame_runt_i,
    output logic [STAT_WIDTH-1:0] ok_count_o,
    output logic [STAT_WIDTH-1:0] drop_count_o,
    output logic [STAT_WIDTH-1:0] runt_count_o
);

    // Holds at all ones once full
    function automatic logic [STAT_WIDTH-1:0] sat_inc(input logic [STAT_WIDTH-1:0] value);
        if (&value) begin
            return value;
        end
        return value + 1'b1;
    endfunction

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ok_count_o   <= '0;
            drop_count_o <= '0;
            runt_count_o <= '0;
        end else begin
            if (frame_ok_i) begin
                ok_count_o <= sat_inc(ok_count_o);
            end
            if (frame_drop_i) begin
                drop_count_o <= sat_inc(drop_count_o);
            end
            if (frame_runt_i) begin
                runt_count_o <= sat_inc(runt_count_o);
            end
        end
    end

endmodule

//--- eth_rx_top.sv
`timescale 1ns/100ps

module eth_rx_top
    import rmii_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  crs_dv_i,
    input  logic [1:0]            rxd_i,
    input  logic [47:0]           local_mac_i,
    output logic [7:0]            m_data_o,
    output logic                  m_valid_o,
    output logic                  m_last_o,
    output logic [STAT_WIDTH-1:0] ok_count_o,
    output logic [STAT_WIDTH-1:0] drop_count_o,
    output logic [STAT_WIDTH-1:0] runt_count_o
);

    logic [7:0] rx_byte;
    logic       rx_byte_stb;
    logic       frame_act;
    logic       frame_ok;
    logic       frame_drop;
    logic       frame_runt;

    rmii_dibit_packer packer_i (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .crs_dv_i    (crs_dv_i),
        .rxd_i       (rxd_i),
        .byte_o      (rx_byte),
        .byte_stb_o  (rx_byte_stb),
        .frame_act_o (frame_act)
    );

    packet_recv recv_i (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .byte_i       (rx_byte),
        .byte_stb_i   (rx_byte_stb),
        .frame_act_i  (frame_act),
        .local_mac_i  (local_mac_i),
        .m_data_o     (m_data_o),
        .m_valid_o    (m_valid_o),
        .m_last_o     (m_last_o),
        .frame_ok_o   (frame_ok),
        .frame_drop_o (frame_drop),
        .frame_runt_o (frame_runt)
    );

    rx_frame_stats stats_i (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .frame_ok_i   (frame_ok),
        .frame_drop_i (frame_drop),
        .frame_runt_i (frame_runt),
        .ok_count_o   (ok_count_o),
        .drop_count_o (drop_count_o),
        .runt_count_o (runt_count_o)
    );

endmodule

//--- tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
    end

    always #2 clk_o = ~clk_o; // 4 ns period

endmodule

//--- tb_eth_rx_checker.sv
`timescale 1ns/100ps

module tb_eth_rx_checker
    import rmii_pkg::*;
(
    input logic                  clk_i,
    input logic                  rst_i,
    input logic [7:0]            m_data_i,
    input logic                  m_valid_i,
    input logic                  m_last_i,
    input logic [STAT_WIDTH-1:0] ok_count_i,
    input logic [STAT_WIDTH-1:0] drop_count_i,
    input logic [STAT_WIDTH-1:0] runt_count_i
);

    logic [8:0] exp_q[$]; // {last, data}
    string      test_name       = "none";
    int         errors          = 0;
    int         tests_run       = 0;
    int         tests_failed    = 0;
    int         errors_at_start = 0;

    function automatic int pending();
        return exp_q.size();
    endfunction

    task automatic begin_test(input string name);
        test_name       = name;
        errors_at_start = errors;
    endtask

    task automatic expect_byte(input logic [7:0] data, input logic last);
        exp_q.push_back({last, data});
    endtask

    task automatic compare_count(input string what, input int expected,
                                 input logic [STAT_WIDTH-1:0] actual);
        if (actual !== STAT_WIDTH'(expected)) begin
            $display("error %s: %s expected %0d actual %0d", test_name, what, expected, actual);
            errors++;
        end
    endtask

    task automatic end_test(input int exp_ok, input int exp_drop, input int exp_runt,
                            input bit drained);
        if (!drained) begin
            $display("%s: DUT did not finish the frame in time", test_name);
            errors++;
        end
        if (exp_q.size() != 0) begin
            $display("%s: %0d payload bytes never came out", test_name, exp_q.size());
            errors++;
            exp_q.delete();
        end
        compare_count("ok_count", exp_ok, ok_count_i);
        compare_count("drop_count", exp_drop, drop_count_i);
        compare_count("runt_count", exp_runt, runt_count_i);
        tests_run++;
        if (errors == errors_at_start) begin
            $display("test %s: pass", test_name);
        end else begin
            tests_failed++;
            $display("test %s: fail", test_name);
        end
    endtask

    // Outputs change on the rising edge, so the falling edge sees them settled
    always @(negedge clk_i) begin
        logic [8:0] entry;
        if (!rst_i) begin
            if (m_valid_i) begin
                if (exp_q.size() == 0) begin
                    $display("%s: byte %h came out with no accepted frame pending",
                             test_name, m_data_i);
                    errors++;
                end else begin
                    entry = exp_q.pop_front();
                    if (m_data_i !== entry[7:0]) begin
                        $display("error %s: data expected %h actual %h",
                                 test_name, entry[7:0], m_data_i);
                        errors++;
                    end
                    if (m_last_i !== entry[8]) begin
                        $display("error %s: last expected %b actual %b",
                                 test_name, entry[8], m_last_i);
                        errors++;
                    end
                end
            end else if (m_last_i) begin
                $display("%s: m_last_o went high without m_valid_o", test_name);
                errors++;
            end
        end
    end

endmodule

//--- tb_eth_rx.sv
`timescale 1ns/100ps

module tb_eth_rx
    import rmii_pkg::*;
();

    localparam int          NUM_FRAMES    = 40;
    localparam int          GAP_CYCLES    = 12;
    localparam int          DRAIN_TIMEOUT = 100;
    localparam logic [47:0] LOCAL_MAC     = 48'h02_1a_2b_3c_4d_5e;

    logic                  clk;
    logic                  rst;
    logic                  crs_dv;
    logic [1:0]            rxd;
    logic [47:0]           local_mac;
    logic [7:0]            m_data;
    logic                  m_valid;
    logic                  m_last;
    logic [STAT_WIDTH-1:0] ok_count;
    logic [STAT_WIDTH-1:0] drop_count;
    logic [STAT_WIDTH-1:0] runt_count;

    integer     seed;
    int         exp_ok;
    int         exp_drop;
    int         exp_runt;
    logic [7:0] frame_q[$];
    string      kind_names[4] = '{"good", "other_mac", "runt", "bad_sfd"};

    tb_clock_gen clock_i (.clk_o(clk));

    eth_rx_top dut_i (
        .clk_i        (clk),
        .rst_i        (rst),
        .crs_dv_i     (crs_dv),
        .rxd_i        (rxd),
        .local_mac_i  (local_mac),
        .m_data_o     (m_data),
        .m_valid_o    (m_valid),
        .m_last_o     (m_last),
        .ok_count_o   (ok_count),
        .drop_count_o (drop_count),
        .runt_count_o (runt_count)
    );

    tb_eth_rx_checker checker_i (
        .clk_i        (clk),
        .rst_i        (rst),
        .m_data_i     (m_data),
        .m_valid_i    (m_valid),
        .m_last_i     (m_last),
        .ok_count_i   (ok_count),
        .drop_count_i (drop_count),
        .runt_count_i (runt_count)
    );

    function automatic logic [7:0] random_byte();
        logic [31:0] rnd;
        rnd = $random(seed);
        return rnd[7:0];
    endfunction

    function automatic int random_below(input int n);
        logic [31:0] rnd;
        rnd = $random(seed);
        return int'(rnd % n);
    endfunction

    // Bad SFD frames carry only even bytes after the SFD, so no 0xd5 can complete a match later
    task automatic build_frame(input int kind);
        logic [47:0] dst;
        logic [7:0]  value;
        logic [7:0]  mask;
        int          pay_len;
        logic        accepted;
        mask     = (kind == 3) ? 8'hfe : 8'hff;
        accepted = (kind == 0) || (kind == 1 && !CHECK_DESTINATION);
        frame_q.delete();
        repeat (7) frame_q.push_back(8'h55);
        value = random_byte();
        frame_q.push_back((kind == 3) ? (value & mask) : 8'hd5);
        for (int k = 0; k < 6; k++) begin
            dst = {dst[39:0], random_byte()};
        end
        if (kind == 0) begin
            dst = LOCAL_MAC;
        end else if (dst == LOCAL_MAC) begin
            dst[0] = ~dst[0];
        end
        for (int k = 5; k >= 0; k--) begin
            frame_q.push_back(dst[8*k +: 8] & mask); // Network order, first byte is MS
        end
        repeat (HEADER_BYTES - 6) frame_q.push_back(random_byte() & mask);
        if (kind == 2) begin
            repeat (HEADER_BYTES - random_below(HEADER_BYTES)) void'(frame_q.pop_back());
            exp_runt++;
        end else begin
            pay_len = 1 + random_below(40); // Last bytes stand in for the FCS
            for (int k = 0; k < pay_len; k++) begin
                value = random_byte() & mask;
                frame_q.push_back(value);
                if (accepted) begin
                    checker_i.expect_byte(value, k == pay_len - 1);
                end
            end
            if (accepted) begin
                exp_ok++;
            end else if (kind == 1) begin
                exp_drop++;
            end
        end
    endtask

    task automatic send_frame();
        logic [7:0] value;
        while (frame_q.size() > 0) begin
            value = frame_q.pop_front();
            for (int d = 0; d < 4; d++) begin
                @(posedge clk);
                crs_dv <= 1'b1;
                rxd    <= value[2*d +: 2]; // LS dibit first
            end
        end
        @(posedge clk);
        crs_dv <= 1'b0;
        rxd    <= 2'b00;
        repeat (GAP_CYCLES) @(posedge clk);
    endtask

    task automatic wait_for_drain(output bit drained);
        drained = 1'b0;
        for (int cycles = 0; cycles < DRAIN_TIMEOUT; cycles++) begin
            @(posedge clk);
            if (checker_i.pending() == 0 && ok_count == exp_ok &&
                drop_count == exp_drop && runt_count == exp_runt) begin
                drained = 1'b1;
                break;
            end
        end
    endtask

    initial begin
        bit drained;
        int kind;
        seed      = 32'heab2;
        rst       = 1'b1;
        crs_dv    = 1'b0;
        rxd       = 2'b00;
        local_mac = LOCAL_MAC;
        exp_ok    = 0;
        exp_drop  = 0;
        exp_runt  = 0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        checker_i.begin_test("reset");
        wait_for_drain(drained);
        checker_i.end_test(exp_ok, exp_drop, exp_runt, drained);
        for (int i = 0; i < NUM_FRAMES; i++) begin
            kind = (i < 4) ? i : random_below(4); // Every kind shows up early
            checker_i.begin_test($sformatf("frame %0d %s", i, kind_names[kind]));
            build_frame(kind);
            send_frame();
            wait_for_drain(drained);
            checker_i.end_test(exp_ok, exp_drop, exp_runt, drained);
        end
        $display("tests %0d, failed %0d, errors %0d",
                 checker_i.tests_run, checker_i.tests_failed, checker_i.errors);
        if (checker_i.errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- vlog.f
rmii_pkg.sv
rmii_dibit_packer.sv
packet_recv.sv
rx_frame_stats.sv
eth_rx_top.sv
tb_clock_gen.sv
tb_eth_rx_checker.sv
tb_eth_rx.sv
